/* Bender.yml */
package:
  name: note_display

sources:
  - files:
      - common/note_display_pkg.sv
      - common/lcd_cmd_if.sv
      - design/spi_frame_receiver.sv
      - design/note_lookup.sv
      - lcd/lcd_sequencer.sv
      - lcd/lcd_bus_driver.sv
      - design/note_display_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/note_display_tb.sv

/* common/lcd_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One LCD command handed from the sequencer to the bus driver
interface lcd_cmd_if
  import note_display_pkg::*;
();

  logic      valid;  // Command present, only while ready
  logic      rs;     // 0 instruction, 1 character data
  lcd_byte_t data;   // Command code or char
  logic      ready;  // Driver idle and able to take a command

  modport source (output valid, output rs, output data, input ready);
  modport sink   (input valid, input rs, input data, output ready);

endinterface

`default_nettype wire

/* common/note_display_pkg.sv */
`default_nettype none

package note_display_pkg;

  //////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////

  localparam int FREQ_W = 16;                   // Serial frame width

  typedef logic [FREQ_W-1:0] freq_t;            // Frequency in Hz
  typedef logic [7:0]        lcd_byte_t;        // LCD bus byte or char code

  //////////////////////////////////////////////////
  // LCD command and character codes
  //////////////////////////////////////////////////

  localparam lcd_byte_t CMD_CLEAR       = 8'h01;  // Clear display
  localparam lcd_byte_t CMD_HOME        = 8'h02;  // Cursor home
  localparam lcd_byte_t CHAR_SPACE      = 8'h20;  // Blank for out-of-range pitch
  localparam lcd_byte_t CHAR_DIGIT_BASE = 8'h30;  // ASCII '0'

  // HD44780 power-up sequence, 8-bit mode, 2 lines
  localparam int INIT_LEN = 8;
  localparam lcd_byte_t INIT_CMDS [INIT_LEN] = '{
    8'h30,  // Function set, first of three
    8'h30,
    8'h30,
    8'h38,  // 8-bit, 2 lines, 5x8 font
    8'h08,  // Display off
    8'h01,  // Clear
    8'h06,  // Entry mode, cursor moves right
    8'h0C   // Display on, no cursor
  };

  //////////////////////////////////////////////////
  // Note table, C2 through B5
  //////////////////////////////////////////////////

  localparam freq_t NOTE_MIN   = 16'd62;        // Below this no note shown
  localparam int    NOTE_COUNT = 28;

  // Inclusive upper bound per note, roughly midway between semitone pairs
  localparam freq_t NOTE_BOUNDS [NOTE_COUNT] = '{
    16'd69,  16'd78,  16'd85,  16'd93,  16'd104, 16'd117, 16'd127,  // Octave 2
    16'd139, 16'd156, 16'd170, 16'd186, 16'd208, 16'd234, 16'd255,  // Octave 3
    16'd278, 16'd312, 16'd340, 16'd371, 16'd416, 16'd467, 16'd509,  // Octave 4
    16'd555, 16'd623, 16'd679, 16'd741, 16'd832, 16'd934, 16'd1046  // Octave 5
  };

  localparam lcd_byte_t NOTE_LETTERS [7] = '{"C", "D", "E", "F", "G", "A", "B"};

  localparam int FIRST_OCTAVE = 2;              // Octave of index 0

endpackage

`default_nettype wire

/* compile.f */
+incdir+sim
common/note_display_pkg.sv
common/lcd_cmd_if.sv
design/spi_frame_receiver.sv
design/note_lookup.sv
lcd/lcd_sequencer.sv
lcd/lcd_bus_driver.sv
design/note_display_top.sv
sim/note_display_tb.sv

/* design/note_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module note_display_top
  import note_display_pkg::*;
#(
  parameter int T_POWERUP = 2400000,  // 100 ms at 24 MHz
  parameter int T_SETUP   = 2,
  parameter int T_PULSE   = 6,
  parameter int T_HOLD    = 1440,     // 60 us
  parameter int T_LONG    = 120000    // 5 ms
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      sclk,
  input  logic      cs,
  input  logic      sdi,
  output lcd_byte_t d,
  output logic      e,
  output logic      rs
);

  logic      freq_valid;
  freq_t     freq;
  logic      note_valid;
  lcd_byte_t letter;
  lcd_byte_t number;

  lcd_cmd_if cmd_bus ();

  // Serial frame in
  spi_frame_receiver u_rx (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .cs         (cs),
    .sdi        (sdi),
    .freq_valid (freq_valid),
    .freq       (freq)
  );

  note_lookup u_lookup (
    .clk        (clk),
    .reset      (reset),
    .freq_valid (freq_valid),
    .freq       (freq),
    .note_valid (note_valid),
    .letter     (letter),
    .number     (number)
  );

  // Clear, home, letter, number
  lcd_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .note_valid (note_valid),
    .letter     (letter),
    .number     (number),
    .cmd        (cmd_bus.source)
  );

  lcd_bus_driver #(
    .T_POWERUP (T_POWERUP),
    .T_SETUP   (T_SETUP),
    .T_PULSE   (T_PULSE),
    .T_HOLD    (T_HOLD),
    .T_LONG    (T_LONG)
  ) u_drv (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd_bus.sink),
    .d     (d),
    .e     (e),
    .rs    (rs)
  );

endmodule

`default_nettype wire

/* design/note_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module note_lookup
  import note_display_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      freq_valid,
  input  freq_t     freq,
  output logic      note_valid,
  output lcd_byte_t letter,
  output lcd_byte_t number
);

  localparam int IDX_W    = $clog2(NOTE_COUNT);
  localparam int LETTER_N = $size(NOTE_LETTERS);  // Notes per octave

  logic             found;
  logic [IDX_W-1:0] idx;         // Index of first bound >= freq
  logic             in_range;
  lcd_byte_t        note_letter;
  lcd_byte_t        note_number;

  //////////////////////////////////////////////////
  // Table search
  //////////////////////////////////////////////////

  // Priority search, lowest matching bound wins
  always_comb begin
    found = 1'b0;
    idx   = '0;
    for (int i = 0; i < NOTE_COUNT; i++) begin
      if (!found && (freq <= NOTE_BOUNDS[i])) begin
        found = 1'b1;
        idx   = IDX_W'(i);
      end
    end
    in_range = found && (freq >= NOTE_MIN);  // Above top bound leaves found low
  end

  // Letter cycles every octave, digit steps once per octave
  assign note_letter = in_range ? NOTE_LETTERS[idx % LETTER_N] : CHAR_SPACE;
  assign note_number = in_range ?
                       CHAR_DIGIT_BASE + lcd_byte_t'(FIRST_OCTAVE + idx / LETTER_N) :
                       CHAR_SPACE;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) note_valid <= 1'b0;
    else       note_valid <= freq_valid;
  end

  // Chars only move with the strobe
  always_ff @(posedge clk) begin
    if (freq_valid) begin
      letter <= note_letter;
      number <= note_number;
    end
  end

endmodule

`default_nettype wire

/* design/spi_frame_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_receiver
  import note_display_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  sclk,
  input  logic  cs,
  input  logic  sdi,
  output logic  freq_valid,
  output freq_t freq
);

  logic [1:0] sclk_s;   // Two-flop synchronizers
  logic [1:0] cs_s;
  logic [1:0] sdi_s;
  logic       sclk_d;   // Edge-detect history
  logic       cs_d;
  logic       sclk_rise;
  logic       cs_rise;
  freq_t      shift_q;  // Last FREQ_W bits seen

  //////////////////////////////////////////////////
  // Synchronizers and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_s <= 2'b00;
      sclk_d <= 1'b0;
      cs_s   <= 2'b11;    // cs idles high, avoids a false frame end
      cs_d   <= 1'b1;
    end else begin
      sclk_s <= {sclk_s[0], sclk};
      sclk_d <= sclk_s[1];
      cs_s   <= {cs_s[0], cs};
      cs_d   <= cs_s[1];
    end
  end

  // Data pin, same latency as sclk so bits line up
  always_ff @(posedge clk) begin
    sdi_s <= {sdi_s[0], sdi};
  end

  assign sclk_rise = sclk_s[1] & ~sclk_d;
  assign cs_rise   = cs_s[1] & ~cs_d;

  //////////////////////////////////////////////////
  // Shift in, MSB first
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sclk_rise && !cs_s[1]) begin
      shift_q <= {shift_q[FREQ_W-2:0], sdi_s[1]};
    end
    if (cs_rise) begin
      freq <= shift_q;  // Frame done, hand it on
    end
  end

  always_ff @(posedge clk) begin
    if (reset) freq_valid <= 1'b0;
    else       freq_valid <= cs_rise;  // One-cycle strobe
  end

endmodule

`default_nettype wire

/* lcd/lcd_bus_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_driver
  import note_display_pkg::*;
#(
  parameter int T_POWERUP = 2400000,
  parameter int T_SETUP   = 2,
  parameter int T_PULSE   = 6,
  parameter int T_HOLD    = 1440,
  parameter int T_LONG    = 120000
) (
  input  logic      clk,
  input  logic      reset,
  lcd_cmd_if.sink   cmd,
  output lcd_byte_t d,
  output logic      e,
  output logic      rs
);

  // Counter sized for the longest interval
  localparam int M_SP   = (T_SETUP > T_PULSE) ? T_SETUP : T_PULSE;
  localparam int M_HOLD = (M_SP > T_HOLD) ? M_SP : T_HOLD;
  localparam int M_LONG = (M_HOLD > T_LONG) ? M_HOLD : T_LONG;
  localparam int T_MAX  = (M_LONG > T_POWERUP) ? M_LONG : T_POWERUP;
  localparam int CNT_W  = $clog2(T_MAX + 1);
  localparam int IDX_W  = $clog2(INIT_LEN);

  typedef enum logic [2:0] {
    PH_POWERUP,
    PH_SETUP,   // d, rs driven, e low
    PH_PULSE,   // e high
    PH_HOLD,    // e low, bus unchanged
    PH_IDLE
  } phase_t;

  phase_t           phase;
  logic [CNT_W-1:0] cnt;          // Cycles left in current phase
  logic             cnt_done;
  logic             init_active;  // Still playing INIT_CMDS
  logic [IDX_W-1:0] init_idx;
  logic [IDX_W-1:0] init_next;
  logic             long_hold;

  assign cnt_done  = (cnt == '0);
  assign init_next = init_idx + 1'b1;

  // Slow commands, plus the very first function set after power-up
  assign long_hold = !rs && ((d == CMD_CLEAR) || (d == CMD_HOME) ||
                             (init_active && (init_idx == '0)));

  assign cmd.ready = (phase == PH_IDLE);
  assign e         = (phase == PH_PULSE);

  //////////////////////////////////////////////////
  // Phase sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase       <= PH_POWERUP;
      cnt         <= CNT_W'(T_POWERUP - 1);
      init_active <= 1'b1;
      init_idx    <= '0;
      d           <= '0;
      rs          <= 1'b0;
    end else begin
      case (phase)
        PH_POWERUP: begin
          if (cnt_done) begin  // Start first init write
            d     <= INIT_CMDS[0];
            rs    <= 1'b0;
            phase <= PH_SETUP;
            cnt   <= CNT_W'(T_SETUP - 1);
          end else cnt <= cnt - 1'b1;
        end
        PH_SETUP: begin
          if (cnt_done) begin
            phase <= PH_PULSE;
            cnt   <= CNT_W'(T_PULSE - 1);
          end else cnt <= cnt - 1'b1;
        end
        PH_PULSE: begin
          if (cnt_done) begin
            phase <= PH_HOLD;
            cnt   <= long_hold ? CNT_W'(T_LONG - 1) : CNT_W'(T_HOLD - 1);
          end else cnt <= cnt - 1'b1;
        end
        PH_HOLD: begin
          if (!cnt_done) begin
            cnt <= cnt - 1'b1;
          end else if (init_active && (init_idx != IDX_W'(INIT_LEN - 1))) begin
            init_idx <= init_next;             // Next init command
            d        <= INIT_CMDS[init_next];
            phase    <= PH_SETUP;
            cnt      <= CNT_W'(T_SETUP - 1);
          end else begin
            init_active <= 1'b0;  // Init done or normal write finished
            phase       <= PH_IDLE;
          end
        end
        default: begin  // PH_IDLE
          if (cmd.valid) begin
            d     <= cmd.data;
            rs    <= cmd.rs;
            phase <= PH_SETUP;
            cnt   <= CNT_W'(T_SETUP - 1);
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* lcd/lcd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer
  import note_display_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          note_valid,
  input  lcd_byte_t     letter,
  input  lcd_byte_t     number,
  lcd_cmd_if.source     cmd
);

  logic       busy;      // Update in progress
  logic [1:0] step;      // 0 clear, 1 home, 2 letter, 3 number
  lcd_byte_t  letter_q;  // Note held for the whole update
  lcd_byte_t  number_q;
  logic       issue;

  //////////////////////////////////////////////////
  // Step control
  //////////////////////////////////////////////////

  assign issue = busy && cmd.ready;  // Driver drops ready next cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      step <= 2'd0;
    end else if (!busy) begin
      if (note_valid) begin  // New notes only taken when idle
        busy <= 1'b1;
        step <= 2'd0;
      end
    end else if (issue) begin
      step <= step + 2'd1;
      if (step == 2'd3) busy <= 1'b0;  // Number sent, back to idle
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && note_valid) begin
      letter_q <= letter;
      number_q <= number;
    end
  end

  //////////////////////////////////////////////////
  // Command mux
  //////////////////////////////////////////////////

  assign cmd.valid = issue;
  assign cmd.rs    = step[1];  // Last two steps are character writes

  always_comb begin
    case (step)
      2'd0:    cmd.data = CMD_CLEAR;
      2'd1:    cmd.data = CMD_HOME;
      2'd2:    cmd.data = letter_q;
      default: cmd.data = number_q;
    endcase
  end

endmodule

`default_nettype wire

/* sim/note_display_ref.svh */
`ifndef NOTE_DISPLAY_REF_SVH
`define NOTE_DISPLAY_REF_SVH

typedef logic [8:0] write_t;  // {rs, d} of one LCD write

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// First bound at or above f picks the note
function automatic logic [15:0] note_ref(input freq_t f);
  int i;
  i = 0;
  if ((f < NOTE_MIN) || (f > NOTE_BOUNDS[NOTE_COUNT-1])) begin
    return {CHAR_SPACE, CHAR_SPACE};  // Out of range
  end
  while (NOTE_BOUNDS[i] < f) i++;
  return {NOTE_LETTERS[i % 7], CHAR_DIGIT_BASE + lcd_byte_t'(FIRST_OCTAVE + i / 7)};
endfunction

// Four writes of one update with the first one in the top bits
function automatic logic [4*9-1:0] expected_writes(input freq_t f);
  logic [15:0] note;
  note = note_ref(f);
  return {1'b0, CMD_CLEAR,
          1'b0, CMD_HOME,
          1'b1, note[15:8],   // Letter
          1'b1, note[7:0]};   // Octave digit
endfunction

//////////////////////////////////////////////////
// Compare
//////////////////////////////////////////////////

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  end
endtask

`endif

/* sim/note_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module note_display_tb
  import note_display_pkg::*;
();

  `include "note_display_ref.svh"

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 5;     // Inputs move after the edge
  localparam int RESET_CYC  = 16;
  localparam int T_POWERUP  = 50;
  localparam int T_SETUP    = 2;
  localparam int T_PULSE    = 3;
  localparam int T_HOLD     = 4;
  localparam int T_LONG     = 10;

  // Run length estimate for the watchdog
  localparam int WRITE_CYC    = T_SETUP + T_PULSE + T_LONG + 2;  // Worst-case write
  localparam int INIT_CYC     = T_POWERUP + INIT_LEN * WRITE_CYC;
  localparam int FRAME_CYC    = 4 * FREQ_W + 16;
  localparam int UPDATE_CYC   = 4 * WRITE_CYC + 8;
  localparam int NUM_FRAMES   = 40;  // Single, boundaries, random, drop test
  localparam int WAIT_LIMIT   = INIT_CYC + UPDATE_CYC;
  localparam int WATCHDOG_CYC = 2 * (RESET_CYC + INIT_CYC + UPDATE_CYC + FRAME_CYC +
                                     NUM_FRAMES * (FRAME_CYC + UPDATE_CYC));

  logic      clk;
  logic      reset;
  logic      sclk;
  logic      cs;
  logic      sdi;
  lcd_byte_t d;
  logic      e;
  logic      rs;

  write_t got_q[$];          // Writes seen on the bus
  write_t exp_q[$];          // Writes still owed
  write_t hist_q[$];         // Bus value of the last T_SETUP cycles
  int     exp_total      = 0;
  int     writes_seen    = 0;
  int     writes_checked = 0;
  int     seed           = 8530;
  logic   e_prev         = 1'b0;
  int     pulse_len      = 0;
  write_t pulse_word     = '0;

  note_display_top #(
    .T_POWERUP (T_POWERUP),
    .T_SETUP   (T_SETUP),
    .T_PULSE   (T_PULSE),
    .T_HOLD    (T_HOLD),
    .T_LONG    (T_LONG)
  ) dut0 (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .cs    (cs),
    .sdi   (sdi),
    .d     (d),
    .e     (e),
    .rs    (rs)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic next_drive(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Low nbits of f MSB first with 4 clk cycles per bit
  task automatic send_frame(input freq_t f, input int nbits);
    next_drive(1);
    cs = 1'b0;
    for (int i = nbits - 1; i >= 0; i--) begin
      next_drive(2);
      sdi  = f[i];
      sclk = 1'b0;
      next_drive(2);
      sclk = 1'b1;  // Receiver shifts here
    end
    next_drive(2);
    sclk = 1'b0;
    next_drive(2);
    cs = 1'b1;      // Frame end
  endtask

  task automatic push_expected(input freq_t f);
    logic [4*9-1:0] w;
    w = expected_writes(f);
    for (int k = 0; k < 4; k++) exp_q.push_back(w[4*9-1-9*k -: 9]);
    exp_total += 4;
  endtask

  task automatic wait_checked(input int target);
    int n;
    n = 0;
    while ((writes_checked < target) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      n++;
    end
    if (writes_checked < target) begin
      $display("LCD write %0d never arrived at %0t ns", target, $time);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic run_frame(input freq_t f);
    push_expected(f);
    send_frame(f, FREQ_W);
    wait_checked(exp_total);  // Whole update seen
  endtask

  //////////////////////////////////////////////////
  // Bus monitor and compare
  //////////////////////////////////////////////////

  always @(negedge clk) begin : bus_monitor
    write_t cur;
    cur = {rs, d};
    if (!reset) begin
      if (e && !e_prev) begin       // Rise of e
        foreach (hist_q[k]) check("d/rs during setup", hist_q[k], cur);
        got_q.push_back(cur);
        writes_seen++;
        pulse_len  = 1;
        pulse_word = cur;
      end else if (e) begin
        pulse_len++;
        check("d/rs during pulse", cur, pulse_word);
      end else if (e_prev) begin
        check("e pulse width", pulse_len, T_PULSE);
      end
      e_prev = e;
    end
    hist_q.push_back(cur);
    if (hist_q.size() > T_SETUP) void'(hist_q.pop_front());
  end

  initial begin : compare_writes
    write_t got;
    write_t exp;
    forever begin
      @(posedge clk);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        if (exp_q.size() == 0) begin
          $display("unexpected LCD write rs %0b d %02h at %0t ns", got[8], got[7:0], $time);
          $display("Simulation failed");
          $fatal(1);
        end else begin
          exp = exp_q.pop_front();
          check("rs", got[8], exp[8]);
          check("d", got[7:0], exp[7:0]);
          writes_checked++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    freq_t f;
    reset = 1'b1;
    sclk  = 1'b0;
    cs    = 1'b1;  // Link idle
    sdi   = 1'b0;
    next_drive(RESET_CYC);
    reset = 1'b0;
    @(negedge clk);
    check("e after reset", e, 1'b0);
    check("rs after reset", rs, 1'b0);
    check("d after reset", d, 8'h00);

    for (int k = 0; k < INIT_LEN; k++) exp_q.push_back({1'b0, INIT_CMDS[k]});
    exp_total = INIT_LEN;
    wait_checked(exp_total);

    run_frame(16'd253);  // B3
    run_frame(16'd61);   // Range edges
    run_frame(16'd62);
    run_frame(16'd69);
    run_frame(16'd70);
    run_frame(16'd1046);
    run_frame(16'd1047);

    for (int k = 0; k < 30; k++) begin
      f = freq_t'($unsigned($random(seed)) % 1101);
      run_frame(f);
    end

    // Short frame lands while the update is busy and must be dropped
    push_expected(16'd440);
    send_frame(16'd440, FREQ_W);
    wait_checked(exp_total - 3);  // First e rise of the update
    send_frame(16'h0009, 4);
    wait_checked(exp_total);
    run_frame(16'd131);  // C3 shown normally

    repeat (UPDATE_CYC + FRAME_CYC) @(posedge clk);
    check("LCD write count", writes_seen, exp_total);
    if ((exp_q.size() == 0) && (got_q.size() == 0)) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d expected LCD writes never appeared", exp_q.size());
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Watchdog timeout, the run did not finish");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

`default_nettype wire
